/* hw/addr_gen.sv */
`timescale 1ns/100ps

module addr_gen (
    input  uop_pkg::uop_t         uop,
    input  arch_pkg::word_t       base,
    input  arch_pkg::word_t       index,
    input  arch_pkg::word_t       aux,
    input  arch_pkg::seg_t [1:0]  seg_val,
    input  arch_pkg::lim_t [1:0]  seg_lim,
    input  arch_pkg::word_t       ecx,
    output arch_pkg::word_t [1:0] mem_addr,
    output arch_pkg::word_t [1:0] mem_addr_end,
    output logic [1:0]            limit_fault,
    output arch_pkg::word_t       rep_count
);

    arch_pkg::word_t       scaled;
    arch_pkg::word_t       sum1;
    arch_pkg::word_t       len_m1;
    arch_pkg::word_t [1:0] offset;
    arch_pkg::word_t [1:0] end_off;
    arch_pkg::word_t [1:0] seg_base;
    logic [1:0]            used;

    assign scaled = index << uop.scale;
    assign sum1   = (uop.uses_base ? base : '0) + (uop.uses_index ? scaled : '0) + uop.disp;

    assign offset[0] = uop.addr32 ? sum1 : {16'h0000, sum1[15:0]};
    assign offset[1] = uop.uses_aux ? aux : '0;
    assign used      = {uop.mem2_used, uop.mem1_used};

    // Access length less one.
    always_comb begin
        case (uop.opsize)
            arch_pkg::sz_byte:  len_m1 = 32'd0;
            arch_pkg::sz_word:  len_m1 = 32'd1;
            arch_pkg::sz_dword: len_m1 = 32'd3;
            default:            len_m1 = 32'd7;
        endcase
    end

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            seg_base[k]     = {12'h000, seg_val[k], 4'h0}; // Real-mode style base.
            end_off[k]      = offset[k] + len_m1;
            mem_addr[k]     = seg_base[k] + offset[k];
            mem_addr_end[k] = mem_addr[k] + len_m1;
            limit_fault[k]  = used[k] && (end_off[k] > {12'h000, seg_lim[k]});
        end
    end

    assign rep_count = uop.rep ? ecx : '0;

endmodule

/* hw/arch_pkg.sv */
package arch_pkg;

    localparam int num_gpr = 8;
    localparam int num_seg = 6;
    localparam int word_w  = 32;
    localparam int tag_w   = 7;

    typedef logic [2:0]        reg_idx_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [15:0]       seg_t;
    typedef logic [19:0]       lim_t;
    typedef logic [tag_w-1:0]  tag_t;

    // Qword only sizes a memory access, never a register.
    typedef enum logic [1:0] {
        sz_byte  = 2'd0,
        sz_word  = 2'd1,
        sz_dword = 2'd2,
        sz_qword = 2'd3
    } opsize_t;

    // General register numbering.
    localparam reg_idx_t eax_idx = 3'd0;
    localparam reg_idx_t ecx_idx = 3'd1; // Repeat count lives here.
    localparam reg_idx_t edx_idx = 3'd2;
    localparam reg_idx_t ebx_idx = 3'd3;
    localparam reg_idx_t esp_idx = 3'd4;
    localparam reg_idx_t ebp_idx = 3'd5;
    localparam reg_idx_t esi_idx = 3'd6;
    localparam reg_idx_t edi_idx = 3'd7;

    // Segment numbering.
    localparam reg_idx_t es_idx = 3'd0;
    localparam reg_idx_t cs_idx = 3'd1;
    localparam reg_idx_t ss_idx = 3'd2;
    localparam reg_idx_t ds_idx = 3'd3;
    localparam reg_idx_t fs_idx = 3'd4;
    localparam reg_idx_t gs_idx = 3'd5;

    // Limits after reset, indexed by segment number (gs down to es).
    localparam lim_t [num_seg-1:0] seg_lim_init = {
        20'h03fff, 20'h00fff, 20'h7ffff, 20'h0ffff, 20'hfffff, 20'h0ffff
    };

endpackage

/* hw/gpr_file.sv */
`timescale 1ns/100ps

module gpr_file (
    input  logic                     clk,
    input  logic                     reset,
    input  arch_pkg::reg_idx_t [3:0] rd_idx,
    input  arch_pkg::opsize_t        rd_size,
    input  uop_pkg::wb_t             wb,
    input  logic                     accept,
    input  logic [3:0]               dest_mask,
    input  arch_pkg::tag_t           cur_tag,
    output uop_pkg::reg_read_t [3:0] rd_data,
    output arch_pkg::word_t [2:0]    addr_val,
    output arch_pkg::word_t          ecx
);

    arch_pkg::word_t              regs [arch_pkg::num_gpr];
    arch_pkg::word_t              regs_wr [arch_pkg::num_gpr]; // Contents after this edge.
    arch_pkg::tag_t               tags [arch_pkg::num_gpr];
    logic [arch_pkg::num_gpr-1:0] pending;
    logic [arch_pkg::num_gpr-1:0] wb_clear;
    logic [arch_pkg::num_gpr-1:0] mark;
    logic                         wb_hit;

    function automatic arch_pkg::word_t merge_sized(input arch_pkg::word_t old_val,
                                                    input arch_pkg::word_t new_val,
                                                    input arch_pkg::opsize_t size);
        case (size)
            arch_pkg::sz_byte: return {old_val[31:8], new_val[7:0]};
            arch_pkg::sz_word: return {old_val[31:16], new_val[15:0]};
            default:           return new_val;
        endcase
    endfunction

    function automatic arch_pkg::word_t zext(input arch_pkg::word_t val,
                                             input arch_pkg::opsize_t size);
        case (size)
            arch_pkg::sz_byte: return {24'h000000, val[7:0]};
            arch_pkg::sz_word: return {16'h0000, val[15:0]};
            default:           return val;
        endcase
    endfunction

    assign wb_hit = wb.valid && !wb.is_seg;

    always_comb begin
        for (int i = 0; i < arch_pkg::num_gpr; i++) begin
            if (wb_hit && wb.index == i) begin
                regs_wr[i]  = merge_sized(regs[i], wb.data, wb.opsize);
                wb_clear[i] = (wb.tag == tags[i]); // Only the latest writer releases.
            end else begin
                regs_wr[i]  = regs[i];
                wb_clear[i] = 1'b0;
            end
            mark[i] = 1'b0;
            for (int p = 0; p < 4; p++) begin
                if (accept && dest_mask[p] && rd_idx[p] == i)
                    mark[i] = 1'b1;
            end
        end
    end

    // Reads see the writeback of the same cycle.
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rd_data[p].value   = zext(regs_wr[rd_idx[p]], rd_size);
            rd_data[p].pending = pending[rd_idx[p]] && !wb_clear[rd_idx[p]];
        end
        for (int k = 0; k < 3; k++)
            addr_val[k] = regs_wr[rd_idx[k + 1]];
    end

    assign ecx = regs_wr[arch_pkg::ecx_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < arch_pkg::num_gpr; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            pending <= (pending & ~wb_clear) | mark; // A new mark beats a release.
            for (int i = 0; i < arch_pkg::num_gpr; i++) begin
                regs[i] <= regs_wr[i];
                if (mark[i])
                    tags[i] <= cur_tag;
            end
        end
    end

    a_wb_size: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> wb.opsize != arch_pkg::sz_qword);

endmodule

/* hw/rrag_ctrl.sv */
`timescale 1ns/100ps

module rrag_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  uop_pkg::uop_t            in_uop,
    input  logic [2:0]               addr_pending, // Base, index, aux.
    input  logic [1:0]               seg_pending,
    input  uop_pkg::reg_read_t [3:0] rd_data,
    input  arch_pkg::seg_t [1:0]     seg_val,
    input  arch_pkg::word_t [1:0]    mem_addr,
    input  arch_pkg::word_t [1:0]    mem_addr_end,
    input  logic [1:0]               limit_fault,
    input  arch_pkg::word_t          rep_count,
    input  logic                     out_stall,
    output logic                     stall,
    output logic                     accept,
    output arch_pkg::tag_t           cur_tag,
    output logic                     out_valid,
    output uop_pkg::rrag_out_t       out_data
);

    uop_pkg::rrag_out_t next_out;
    logic               out_hold;
    logic               hazard;

    assign out_hold = out_valid && out_stall;

    // Only registers feeding an address hold the micro-op back.
    assign hazard = in_valid &&
                    ((in_uop.uses_base  && addr_pending[0]) ||
                     (in_uop.uses_index && addr_pending[1]) ||
                     (in_uop.mem2_used  && addr_pending[2]) ||
                     (in_uop.mem1_used  && seg_pending[0])  ||
                     (in_uop.mem2_used  && seg_pending[1]));

    assign stall  = out_hold || hazard;
    assign accept = in_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset)
            cur_tag <= '0;
        else if (accept)
            cur_tag <= cur_tag + 1'b1; // Wraps at 128.
    end

    always_comb begin
        next_out.tag          = cur_tag;
        next_out.regs         = rd_data;
        next_out.seg_val      = seg_val;
        next_out.mem_addr     = mem_addr;
        next_out.mem_addr_end = mem_addr_end;
        next_out.limit_fault  = limit_fault;
        next_out.rep_count    = rep_count;
        next_out.reg_idx      = in_uop.reg_idx;
        next_out.seg_idx      = in_uop.seg_idx;
        next_out.reg_dest     = in_uop.reg_dest;
        next_out.seg_dest     = in_uop.seg_dest;
        next_out.ctrl         = in_uop.ctrl;
    end

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (!out_hold)
            out_valid <= accept;
    end

    // Accept is never high while the output is held.
    always_ff @(posedge clk) begin
        if (accept)
            out_data <= next_out;
    end

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_hold |=> $stable(out_data));

endmodule

/* hw/rrag_top.sv */
`timescale 1ns/100ps

module rrag_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  uop_pkg::uop_t      in_uop,
    output logic               stall,
    input  uop_pkg::wb_t       wb,
    output logic               out_valid,
    output uop_pkg::rrag_out_t out_data,
    input  logic               out_stall
);

    uop_pkg::reg_read_t [3:0] rd_data;
    arch_pkg::word_t [2:0]    addr_val;
    arch_pkg::word_t          ecx;
    arch_pkg::seg_t [1:0]     seg_val;
    arch_pkg::lim_t [1:0]     seg_lim;
    logic [1:0]               seg_pending;
    arch_pkg::word_t [1:0]    mem_addr;
    arch_pkg::word_t [1:0]    mem_addr_end;
    logic [1:0]               limit_fault;
    arch_pkg::word_t          rep_count;
    logic                     accept;
    arch_pkg::tag_t           cur_tag;

    gpr_file gprs0 (.clk(clk), .reset(reset), .rd_idx(in_uop.reg_idx), .rd_size(in_uop.opsize),
                    .wb(wb), .accept(accept), .dest_mask(in_uop.reg_dest), .cur_tag(cur_tag),
                    .rd_data(rd_data), .addr_val(addr_val), .ecx(ecx));

    seg_file segs0 (.clk(clk), .reset(reset), .rd_idx(in_uop.seg_idx), .wb(wb),
                    .accept(accept), .dest_mask(in_uop.seg_dest), .cur_tag(cur_tag),
                    .seg_val(seg_val), .seg_lim(seg_lim), .seg_pending(seg_pending));

    addr_gen agu0 (.uop(in_uop), .base(addr_val[0]), .index(addr_val[1]), .aux(addr_val[2]),
                   .seg_val(seg_val), .seg_lim(seg_lim), .ecx(ecx), .mem_addr(mem_addr),
                   .mem_addr_end(mem_addr_end), .limit_fault(limit_fault),
                   .rep_count(rep_count));

    rrag_ctrl ctrl0 (.clk(clk), .reset(reset), .in_valid(in_valid), .in_uop(in_uop),
                     .addr_pending({rd_data[3].pending, rd_data[2].pending, rd_data[1].pending}),
                     .seg_pending(seg_pending), .rd_data(rd_data), .seg_val(seg_val),
                     .mem_addr(mem_addr), .mem_addr_end(mem_addr_end),
                     .limit_fault(limit_fault), .rep_count(rep_count), .out_stall(out_stall),
                     .stall(stall), .accept(accept), .cur_tag(cur_tag),
                     .out_valid(out_valid), .out_data(out_data));

endmodule

/* hw/seg_file.sv */
`timescale 1ns/100ps

module seg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  arch_pkg::reg_idx_t [1:0] rd_idx,
    input  uop_pkg::wb_t             wb,
    input  logic                     accept,
    input  logic [1:0]               dest_mask,
    input  arch_pkg::tag_t           cur_tag,
    output arch_pkg::seg_t [1:0]     seg_val,
    output arch_pkg::lim_t [1:0]     seg_lim,
    output logic [1:0]               seg_pending
);

    arch_pkg::seg_t               sel [arch_pkg::num_seg];
    arch_pkg::seg_t               sel_wr [arch_pkg::num_seg];
    arch_pkg::lim_t               lim [arch_pkg::num_seg];
    arch_pkg::tag_t               tags [arch_pkg::num_seg];
    logic [arch_pkg::num_seg-1:0] pending;
    logic [arch_pkg::num_seg-1:0] wb_clear;
    logic [arch_pkg::num_seg-1:0] mark;

    always_comb begin
        for (int i = 0; i < arch_pkg::num_seg; i++) begin
            if (wb.valid && wb.is_seg && wb.index == i) begin
                sel_wr[i]   = wb.data[15:0];
                wb_clear[i] = (wb.tag == tags[i]);
            end else begin
                sel_wr[i]   = sel[i];
                wb_clear[i] = 1'b0;
            end
            mark[i] = (accept && dest_mask[0] && rd_idx[0] == i) ||
                      (accept && dest_mask[1] && rd_idx[1] == i);
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            seg_val[p]     = sel_wr[rd_idx[p]]; // Write-first.
            seg_lim[p]     = lim[rd_idx[p]];
            seg_pending[p] = pending[rd_idx[p]] && !wb_clear[rd_idx[p]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < arch_pkg::num_seg; i++) begin
                sel[i]  <= '0;
                lim[i]  <= arch_pkg::seg_lim_init[i];
                tags[i] <= '0;
            end
        end else begin
            pending <= (pending & ~wb_clear) | mark;
            for (int i = 0; i < arch_pkg::num_seg; i++) begin
                sel[i] <= sel_wr[i];
                if (mark[i])
                    tags[i] <= cur_tag;
            end
        end
    end

    a_rd_idx: assert property (@(posedge clk) disable iff (reset)
        accept |-> rd_idx[0] < arch_pkg::num_seg && rd_idx[1] < arch_pkg::num_seg);
    a_wb_idx: assert property (@(posedge clk) disable iff (reset)
        (wb.valid && wb.is_seg) |-> wb.index < arch_pkg::num_seg);

endmodule

/* hw/uop_pkg.sv */
package uop_pkg;

    // Execute controls carried through untouched.
    typedef struct packed {
        logic [4:0]      aluk;
        logic [22:0]     p_op;
        logic [17:0]     fmask;
        logic [47:0]     imm;
        logic            is_br;
        logic            br_pred_taken;
        arch_pkg::word_t br_pred_target;
        arch_pkg::word_t eip;
    } ctrl_payload_t;

    // reg_idx[0] is the data operand, [1] base, [2] index, [3] aux.
    typedef struct packed {
        arch_pkg::reg_idx_t [3:0] reg_idx;
        logic                     uses_base;
        logic                     uses_index;
        logic                     uses_aux;
        logic [1:0]               scale;
        arch_pkg::reg_idx_t [1:0] seg_idx;  // Segment of access 1 and access 2.
        arch_pkg::word_t          disp;
        logic                     addr32;   // 1 for 32-bit addressing.
        arch_pkg::opsize_t        opsize;
        logic                     mem1_used;
        logic                     mem2_used;
        logic                     rep;
        logic [3:0]               reg_dest;
        logic [1:0]               seg_dest;
        ctrl_payload_t            ctrl;
    } uop_t;

    typedef struct packed {
        logic               valid;
        logic               is_seg;
        arch_pkg::reg_idx_t index;
        arch_pkg::opsize_t  opsize;
        arch_pkg::word_t    data;   // Segment writes use the low 16 bits.
        arch_pkg::tag_t     tag;
    } wb_t;

    typedef struct packed {
        arch_pkg::word_t value;
        logic            pending;
    } reg_read_t;

    typedef struct packed {
        arch_pkg::tag_t           tag;
        reg_read_t [3:0]          regs;
        arch_pkg::seg_t [1:0]     seg_val;
        arch_pkg::word_t [1:0]    mem_addr;
        arch_pkg::word_t [1:0]    mem_addr_end;
        logic [1:0]               limit_fault;
        arch_pkg::word_t          rep_count;
        arch_pkg::reg_idx_t [3:0] reg_idx;
        arch_pkg::reg_idx_t [1:0] seg_idx;
        logic [3:0]               reg_dest;
        logic [1:0]               seg_dest;
        ctrl_payload_t            ctrl;
    } rrag_out_t;

endpackage

/* sources.f */
hw/arch_pkg.sv
hw/uop_pkg.sv
hw/gpr_file.sv
hw/seg_file.sv
hw/addr_gen.sv
hw/rrag_ctrl.sv
hw/rrag_top.sv
test/tb_clock.sv
test/rrag_tb.sv

/* test/rrag_tb.sv */
`timescale 1ns/100ps

module rrag_tb;

    localparam int budget_cycles = 60 + 80 + 60 + 200 + 100 + 100; // Tests plus margin.
    localparam int stream_len    = 8;

    logic               clk;
    logic               reset;
    logic               in_valid;
    uop_pkg::uop_t      in_uop;
    logic               stall;
    uop_pkg::wb_t       wb;
    logic               out_valid;
    uop_pkg::rrag_out_t out_data;
    logic               out_stall;

    arch_pkg::word_t    gpr_model [arch_pkg::num_gpr];
    arch_pkg::seg_t     seg_model [arch_pkg::num_seg];
    arch_pkg::tag_t     exp_tag;
    logic [31:0]        rng_state;
    int                 errors;
    int                 checks;
    int                 cycles;
    int                 n_seen;

    tb_clock clk0 (.clk(clk), .reset(reset));

    rrag_top dut0 (.clk(clk), .reset(reset), .in_valid(in_valid), .in_uop(in_uop),
                   .stall(stall), .wb(wb), .out_valid(out_valid), .out_data(out_data),
                   .out_stall(out_stall));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > budget_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles.", budget_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic arch_pkg::word_t size_mask(input arch_pkg::opsize_t size);
        case (size)
            arch_pkg::sz_byte: return 32'h0000_00ff;
            arch_pkg::sz_word: return 32'h0000_ffff;
            default:           return 32'hffff_ffff;
        endcase
    endfunction

    function automatic arch_pkg::word_t len_bytes(input arch_pkg::opsize_t size);
        return 32'd1 << size; // 1, 2, 4 or 8 bytes.
    endfunction

    function automatic arch_pkg::word_t seg_base(input arch_pkg::reg_idx_t s);
        return 32'(seg_model[s]) * 32'd16;
    endfunction

    function automatic uop_pkg::wb_t make_wb(input logic is_seg, input arch_pkg::reg_idx_t idx,
                                             input arch_pkg::opsize_t size,
                                             input arch_pkg::word_t data,
                                             input arch_pkg::tag_t tag);
        uop_pkg::wb_t w;
        w.valid  = 1'b1;
        w.is_seg = is_seg;
        w.index  = idx;
        w.opsize = size;
        w.data   = data;
        w.tag    = tag;
        return w;
    endfunction

    task automatic check_word(input string what, input arch_pkg::word_t got,
                              input arch_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_read(input string what, input uop_pkg::reg_read_t got,
                                  input uop_pkg::reg_read_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h/%b expected %h/%b", $time, what,
                     got.value, got.pending, exp.value, exp.pending);
        end
    endtask

    task automatic check_tag(input string what, input arch_pkg::tag_t got,
                             input arch_pkg::tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic apply_wb(input uop_pkg::wb_t w);
        @(posedge clk);
        wb <= w;
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic write_gpr(input arch_pkg::reg_idx_t idx, input arch_pkg::opsize_t size,
                             input arch_pkg::word_t data, input arch_pkg::tag_t tag);
        apply_wb(make_wb(1'b0, idx, size, data, tag));
        gpr_model[idx] = (gpr_model[idx] & ~size_mask(size)) | (data & size_mask(size));
    endtask

    task automatic write_seg(input arch_pkg::reg_idx_t idx, input arch_pkg::seg_t sel);
        apply_wb(make_wb(1'b1, idx, arch_pkg::sz_word, {16'h0000, sel}, '0));
        seg_model[idx] = sel;
    endtask

    // Holds the micro-op until accepted, then returns the registered result.
    task automatic issue(input uop_pkg::uop_t u, output uop_pkg::rrag_out_t o);
        @(posedge clk);
        in_valid <= 1'b1;
        in_uop   <= u;
        do
            @(negedge clk);
        while (stall);
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_bit("out_valid one cycle after accept", out_valid, 1'b1);
        check_tag("tag", out_data.tag, exp_tag);
        exp_tag++;
        o = out_data;
    endtask

    task automatic test_sized_rw();
        uop_pkg::uop_t      u;
        uop_pkg::rrag_out_t o;
        uop_pkg::reg_read_t exp_rr;
        arch_pkg::reg_idx_t r;
        for (int w = 0; w < 3; w++) begin
            r = 3'(xorshift());
            // Full fill first so a narrow write has upper bits to keep.
            write_gpr(r, arch_pkg::sz_dword, xorshift(), '0);
            write_gpr(r, arch_pkg::opsize_t'(w), xorshift(), '0);
            for (int s = 0; s < 3; s++) begin
                u = '0;
                u.opsize = arch_pkg::opsize_t'(s);
                for (int p = 1; p < 4; p++)
                    u.reg_idx[p] = 3'(xorshift());
                u.reg_idx[0] = r;
                issue(u, o);
                for (int p = 0; p < 4; p++) begin
                    exp_rr.value   = gpr_model[u.reg_idx[p]] & size_mask(u.opsize);
                    exp_rr.pending = 1'b0;
                    check_reg_read("sized read", o.regs[p], exp_rr);
                end
            end
        end
    endtask

    task automatic test_addr_gen();
        uop_pkg::uop_t      u;
        uop_pkg::rrag_out_t o;
        arch_pkg::word_t    off;
        arch_pkg::word_t    addr;
        for (int i = 0; i < arch_pkg::num_gpr; i++)
            write_gpr(3'(i), arch_pkg::sz_dword, xorshift(), '0);
        write_seg(arch_pkg::ds_idx, 16'(xorshift()));
        write_seg(arch_pkg::es_idx, 16'(xorshift()));
        for (int n = 0; n < 8; n++) begin
            u = '0;
            u.reg_idx[1]  = 3'(xorshift());
            u.reg_idx[2]  = 3'(xorshift());
            u.reg_idx[3]  = 3'(xorshift());
            u.uses_base   = 1'b1;
            u.uses_index  = 1'b1;
            u.uses_aux    = 1'b1;
            u.scale       = 2'(xorshift());
            u.disp        = xorshift();
            u.addr32      = n[0]; // Alternate 16-bit and 32-bit modes.
            u.opsize      = arch_pkg::opsize_t'(2'(xorshift()));
            u.mem1_used   = 1'b1;
            u.mem2_used   = 1'b1;
            u.seg_idx[0]  = arch_pkg::ds_idx;
            u.seg_idx[1]  = arch_pkg::es_idx;
            issue(u, o);
            check_word("seg_val[0]", o.seg_val[0], seg_model[arch_pkg::ds_idx]);
            check_word("seg_val[1]", o.seg_val[1], seg_model[arch_pkg::es_idx]);
            off = gpr_model[u.reg_idx[1]] + (gpr_model[u.reg_idx[2]] << u.scale) + u.disp;
            if (!u.addr32)
                off = off & 32'h0000_ffff;
            addr = seg_base(arch_pkg::ds_idx) + off;
            check_word("mem_addr[0]", o.mem_addr[0], addr);
            check_word("mem_addr_end[0]", o.mem_addr_end[0], addr + len_bytes(u.opsize) - 1);
            addr = seg_base(arch_pkg::es_idx) + gpr_model[u.reg_idx[3]];
            check_word("mem_addr[1]", o.mem_addr[1], addr);
            check_word("mem_addr_end[1]", o.mem_addr_end[1], addr + len_bytes(u.opsize) - 1);
        end
    endtask

    task automatic test_hazard();
        uop_pkg::uop_t      u;
        uop_pkg::rrag_out_t o;
        uop_pkg::reg_read_t exp_rr;
        arch_pkg::tag_t     t_w;
        arch_pkg::word_t    new_val;
        u = '0;
        u.reg_idx[0]  = arch_pkg::ebx_idx;
        u.reg_dest[0] = 1'b1;
        issue(u, o);
        t_w     = o.tag;
        new_val = xorshift();
        u = '0;
        u.reg_idx[1] = arch_pkg::ebx_idx;
        u.uses_base  = 1'b1;
        u.mem1_used  = 1'b1;
        u.addr32     = 1'b1;
        u.seg_idx[0] = arch_pkg::ds_idx;
        u.disp       = 32'h40;
        @(posedge clk);
        in_valid <= 1'b1;
        in_uop   <= u;
        repeat (3) begin
            @(negedge clk);
            check_bit("stall on pending base", stall, 1'b1);
        end
        @(posedge clk);
        wb <= make_wb(1'b0, arch_pkg::ebx_idx, arch_pkg::sz_dword, xorshift(),
                      arch_pkg::tag_t'(t_w + 1)); // Older writer.
        @(negedge clk);
        check_bit("stall with stale writeback", stall, 1'b1);
        @(posedge clk);
        wb <= make_wb(1'b0, arch_pkg::ebx_idx, arch_pkg::sz_dword, new_val, t_w);
        @(negedge clk);
        check_bit("release on matching writeback", stall, 1'b0);
        @(posedge clk);
        in_valid <= 1'b0;
        wb       <= '0;
        gpr_model[arch_pkg::ebx_idx] = new_val;
        @(negedge clk);
        check_bit("out_valid after release", out_valid, 1'b1);
        check_tag("released tag", out_data.tag, exp_tag);
        exp_tag++;
        check_word("address with new base", out_data.mem_addr[0],
                   seg_base(arch_pkg::ds_idx) + new_val + 32'h40);
        // A pending data operand passes with its flag set.
        u = '0;
        u.reg_idx[0]  = arch_pkg::ebx_idx;
        u.reg_dest[0] = 1'b1;
        issue(u, o);
        t_w = o.tag;
        u.reg_dest[0] = 1'b0;
        issue(u, o);
        exp_rr.value   = gpr_model[arch_pkg::ebx_idx] & size_mask(u.opsize);
        exp_rr.pending = 1'b1;
        check_reg_read("pending data operand", o.regs[0], exp_rr);
        write_gpr(arch_pkg::ebx_idx, arch_pkg::sz_dword, xorshift(), t_w);
    endtask

    task automatic test_back_pressure();
        uop_pkg::uop_t      q [stream_len];
        uop_pkg::rrag_out_t held;
        arch_pkg::tag_t     first_tag;
        logic               was_held;
        for (int i = 0; i < stream_len; i++) begin
            q[i]          = '0;
            q[i].disp     = xorshift();
            q[i].ctrl.eip = xorshift();
        end
        first_tag = exp_tag;
        n_seen    = 0;
        was_held  = 1'b0;
        fork
            begin
                for (int i = 0; i < stream_len; i++) begin
                    @(posedge clk);
                    in_valid <= 1'b1;
                    in_uop   <= q[i];
                    do
                        @(negedge clk);
                    while (stall);
                end
                @(posedge clk);
                in_valid <= 1'b0;
            end
            begin
                while (n_seen < stream_len) begin
                    @(posedge clk);
                    out_stall <= (xorshift() % 4) != 0;
                end
                out_stall <= 1'b0;
            end
            begin
                while (n_seen < stream_len) begin
                    @(negedge clk);
                    if (was_held) begin
                        check_bit("out_valid while held", out_valid, 1'b1);
                        check_tag("tag while held", out_data.tag, held.tag);
                        check_word("eip while held", out_data.ctrl.eip, held.ctrl.eip);
                    end
                    was_held = out_valid && out_stall;
                    held     = out_data;
                    if (out_valid && !out_stall) begin
                        check_tag("stream order", out_data.tag,
                                  arch_pkg::tag_t'(first_tag + n_seen));
                        check_word("stream eip", out_data.ctrl.eip, q[n_seen].ctrl.eip);
                        n_seen++;
                    end
                end
            end
        join
        exp_tag = arch_pkg::tag_t'(first_tag + stream_len);
    endtask

    task automatic test_limits_rep();
        uop_pkg::uop_t      u;
        uop_pkg::rrag_out_t o;
        arch_pkg::word_t    lim;
        write_gpr(arch_pkg::ecx_idx, arch_pkg::sz_dword, xorshift(), '0);
        for (int s = 0; s < arch_pkg::num_seg; s++) begin
            for (int beyond = 0; beyond < 2; beyond++) begin
                lim = 32'(arch_pkg::seg_lim_init[s]);
                write_gpr(arch_pkg::edi_idx, arch_pkg::sz_dword, lim - 3 + beyond, '0);
                u = '0;
                u.opsize     = arch_pkg::sz_dword;
                u.addr32     = 1'b1;
                u.disp       = lim - 3 + beyond; // Last byte at the limit, or one past.
                u.mem1_used  = 1'b1;
                u.mem2_used  = 1'b1;
                u.uses_aux   = 1'b1;
                u.reg_idx[3] = arch_pkg::edi_idx;
                u.seg_idx[0] = 3'(s);
                u.seg_idx[1] = 3'(s);
                u.rep        = s[0] ^ beyond[0];
                issue(u, o);
                check_bit("limit_fault[0]", o.limit_fault[0], beyond[0]);
                check_bit("limit_fault[1]", o.limit_fault[1], beyond[0]);
                check_word("rep_count", o.rep_count,
                           u.rep ? gpr_model[arch_pkg::ecx_idx] : 32'd0);
            end
        end
    endtask

    initial begin
        in_valid  = 1'b0;
        in_uop    = '0;
        wb        = '0;
        out_stall = 1'b0;
        rng_state = 32'd25385;
        exp_tag   = '0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        for (int i = 0; i < arch_pkg::num_gpr; i++)
            gpr_model[i] = '0;
        for (int i = 0; i < arch_pkg::num_seg; i++)
            seg_model[i] = '0;
        @(negedge clk);
        while (reset !== 1'b0)
            @(negedge clk);
        check_bit("out_valid after reset", out_valid, 1'b0);
        check_bit("stall after reset", stall, 1'b0);
        test_sized_rw();
        test_addr_gen();
        test_hazard();
        test_back_pressure();
        test_limits_rep();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
